// File: hdl/rename_config.svh
// ==========================================================
// rename stage configuration
// sizes of the commit window, register file, decode group
// and the payload fields carried through rename
// ==========================================================
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// commit stations in the circular window
`define RN_NCOMMIT 16
`define RN_LNCOMMIT 4

// architectural integer registers, x0 is never renamed
`define RN_NARCH 32

// operand tag, flag bit plus five payload bits
`define RN_TAG_W 6

// decode entries offered per cycle and rename slots
`define RN_NENTRY 4
`define RN_NSLOT 2

`define RN_VA_SZ 32
`define RN_CNTRL_SIZE 7

`endif

// File: hdl/rename_pkg.sv
// ==========================================================
// rename types
// operand tag union plus the index types shared by the
// rename blocks, with helpers that build either tag view
// ==========================================================
`default_nettype none
`include "rename_config.svh"

package rename_pkg;

	typedef logic [`RN_LNCOMMIT-1:0] commit_idx_t;
	typedef logic [`RN_TAG_W-2:0] arch_reg_t;
	typedef logic [$clog2(`RN_NENTRY)-1:0] entry_idx_t;

	// flag set means the value comes from a commit station
	typedef union packed {
		struct packed {
			logic flag;
			logic [`RN_TAG_W-`RN_LNCOMMIT-2:0] pad;
			commit_idx_t idx;
		} station;
		struct packed {
			logic flag;
			arch_reg_t num;
		} arch;
	} reg_tag_t;

	function automatic reg_tag_t tag_arch(arch_reg_t r);
		reg_tag_t t;
		t.arch.flag = 1'b0;
		t.arch.num = r;
		return t;
	endfunction

	function automatic reg_tag_t tag_station(commit_idx_t idx);
		reg_tag_t t;
		t.station.flag = 1'b1;
		t.station.pad = '0;
		t.station.idx = idx;
		return t;
	endfunction

endpackage

`default_nettype wire

// File: hdl/entry_select.sv
// ==========================================================
// entry select
// finds the first and second valid decode entries and
// steers them to the two rename slots
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module entry_select
	import rename_pkg::*;
(
	input  wire logic [`RN_NENTRY-1:0] entry_valid,
	output logic [`RN_NSLOT-1:0] slot_valid,
	output entry_idx_t slot_entry [`RN_NSLOT]
);

	// slot k takes the (k+1)th valid entry in decode order
	always_comb begin
		int n;
		n = 0;
		slot_valid = '0;
		for (int k = 0; k < `RN_NSLOT; k++) begin
			slot_entry[k] = '0;
		end
		for (int i = 0; i < `RN_NENTRY; i++) begin
			if (entry_valid[i]) begin
				if (n < `RN_NSLOT) begin
					slot_valid[n] = 1'b1;
					slot_entry[n] = entry_idx_t'(i);
				end
				n++;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/rename_ctrl.sv
// ==========================================================
// rename control
// station demand against availability, accept and count
// for the commit unit, and the reload window after a flush
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module rename_ctrl (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic [`RN_NSLOT-1:0] slot_valid,
	input  wire logic [`RN_LNCOMMIT:0] current_available,
	input  wire logic commit_br_enable,
	output logic accept,
	output logic [$clog2(`RN_NSLOT+1)-1:0] count_out,
	output logic rename_stall,
	output logic rename_reloading
);

	logic [$clog2(`RN_NSLOT+1)-1:0] needed;
	logic [1:0] flush_sr;

	// one station per valid slot
	always_comb begin
		needed = '0;
		for (int k = 0; k < `RN_NSLOT; k++) begin
			needed = needed + slot_valid[k];
		end
	end

	assign rename_stall = needed > current_available;

	// two cycle bubble while fetch and decode refill
	always_ff @(posedge clk) begin
		if (reset) begin
			flush_sr <= '0;
		end else begin
			flush_sr <= {flush_sr[0], commit_br_enable};
		end
	end

	assign rename_reloading = |flush_sr;

	assign accept = |slot_valid && !rename_stall && !rename_reloading;

	// commit unit advances its allocation pointer by this
	assign count_out = accept ? needed : '0;

endmodule

`default_nettype wire

// File: hdl/reg_scoreboard.sv
// ==========================================================
// register scoreboard
// one tag per architectural register naming the newest
// pending commit station, or the register itself once that
// station retires or a branch flush kills younger work
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module reg_scoreboard
	import rename_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic accept,
	input  wire logic [`RN_NSLOT-1:0] upd_valid,
	input  wire arch_reg_t upd_reg [`RN_NSLOT],
	input  wire commit_idx_t upd_idx [`RN_NSLOT],
	input  wire logic [`RN_NCOMMIT-1:0] commit_retire,
	input  wire logic commit_br_enable,
	output reg_tag_t reg_tag [`RN_NARCH]
);

	// x0 reads as zero and is never renamed
	assign reg_tag[0] = tag_arch('0);

	for (genvar r = 1; r < `RN_NARCH; r++) begin : g_reg
		reg_tag_t tag_q;
		logic hit0;
		logic hit1;
		logic retired;

		assign hit0 = accept && upd_valid[0] && upd_reg[0] == arch_reg_t'(r);
		assign hit1 = accept && upd_valid[1] && upd_reg[1] == arch_reg_t'(r);
		assign retired = tag_q.station.flag && commit_retire[tag_q.station.idx];

		always_ff @(posedge clk) begin
			if (reset || commit_br_enable) begin
				tag_q <= tag_arch(arch_reg_t'(r));
			end else if (hit1) begin
				// slot 1 is younger so it owns the final mapping
				tag_q <= tag_station(upd_idx[1]);
			end else if (hit0) begin
				tag_q <= tag_station(upd_idx[0]);
			end else if (retired) begin
				tag_q <= tag_arch(arch_reg_t'(r));
			end
		end

		assign reg_tag[r] = tag_q;
	end

endmodule

`default_nettype wire

// File: hdl/operand_map.sv
// ==========================================================
// operand map
// source lookup with in-group bypass from slot 0 and
// done-check, plus destination station per slot
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module operand_map
	import rename_pkg::*;
(
	input  wire logic [`RN_NSLOT-1:0] slot_valid,
	input  wire entry_idx_t slot_entry [`RN_NSLOT],
	input  wire arch_reg_t rs1 [`RN_NENTRY],
	input  wire arch_reg_t rs2 [`RN_NENTRY],
	input  wire arch_reg_t rd [`RN_NENTRY],
	input  wire logic [`RN_NENTRY-1:0] makes_rd,
	input  wire commit_idx_t next_start,
	input  wire reg_tag_t reg_tag [`RN_NARCH],
	input  wire logic [`RN_NCOMMIT-1:0] commit_done,
	output reg_tag_t src1_tag [`RN_NSLOT],
	output reg_tag_t src2_tag [`RN_NSLOT],
	output commit_idx_t dest_idx [`RN_NSLOT],
	output logic [`RN_NSLOT-1:0] upd_valid
);

	function automatic reg_tag_t lookup(arch_reg_t src, reg_tag_t cur, logic byp_en,
		arch_reg_t byp_reg, commit_idx_t byp_idx, logic [`RN_NCOMMIT-1:0] done);
		reg_tag_t t;
		t = cur;
		// older instruction in the same group wrote this register
		if (byp_en && byp_reg == src) begin
			t = tag_station(byp_idx);
		end
		if (t.station.flag && done[t.station.idx]) begin
			t = tag_arch(src);
		end
		// x0 stays architectural whatever the table says
		if (src == '0) begin
			t = tag_arch('0);
		end
		return t;
	endfunction

	for (genvar k = 0; k < `RN_NSLOT; k++) begin : g_dest
		assign dest_idx[k] = next_start + commit_idx_t'(k);
		assign upd_valid[k] = slot_valid[k] && makes_rd[slot_entry[k]] &&
			rd[slot_entry[k]] != '0;
	end

	// slot 0 never bypasses
	assign src1_tag[0] = lookup(rs1[slot_entry[0]], reg_tag[rs1[slot_entry[0]]],
		1'b0, '0, '0, commit_done);
	assign src2_tag[0] = lookup(rs2[slot_entry[0]], reg_tag[rs2[slot_entry[0]]],
		1'b0, '0, '0, commit_done);

	assign src1_tag[1] = lookup(rs1[slot_entry[1]], reg_tag[rs1[slot_entry[1]]],
		upd_valid[0], rd[slot_entry[0]], dest_idx[0], commit_done);
	assign src2_tag[1] = lookup(rs2[slot_entry[1]], reg_tag[rs2[slot_entry[1]]],
		upd_valid[0], rd[slot_entry[0]], dest_idx[0], commit_done);

endmodule

`default_nettype wire

// File: hdl/rename_slot.sv
// ==========================================================
// rename slot
// output register for one renamed instruction, holds its
// payload under stall and turns held station tags back to
// architectural as their producers finish
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module rename_slot
	import rename_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic accept,
	input  wire logic rename_stall,
	input  wire logic slot_valid_in,
	input  wire reg_tag_t src1_tag,
	input  wire reg_tag_t src2_tag,
	input  wire commit_idx_t dest_idx,
	input  wire arch_reg_t rs1,
	input  wire arch_reg_t rs2,
	input  wire arch_reg_t rd,
	input  wire logic needs_rs2,
	input  wire logic makes_rd,
	input  wire logic [`RN_CNTRL_SIZE-1:0] control,
	input  wire logic [`RN_VA_SZ-1:0] pc,
	input  wire logic [`RN_NCOMMIT-1:0] commit_done,
	output logic valid_out,
	output reg_tag_t rs1_out,
	output reg_tag_t rs2_out,
	output commit_idx_t rd_out,
	output arch_reg_t rd_real_out,
	output logic makes_rd_out,
	output logic needs_rs2_out,
	output logic [`RN_CNTRL_SIZE-1:0] control_out,
	output logic [`RN_VA_SZ-1:0] pc_out
);

	logic valid_q;
	reg_tag_t rs1_q;
	reg_tag_t rs2_q;
	arch_reg_t real_rs1_q;
	arch_reg_t real_rs2_q;
	commit_idx_t rd_q;
	arch_reg_t rd_real_q;
	logic makes_rd_q;
	logic needs_rs2_q;
	logic [`RN_CNTRL_SIZE-1:0] control_q;
	logic [`RN_VA_SZ-1:0] pc_q;

	// accept already excludes stall, so a held slot shows invalid
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= slot_valid_in && accept;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rs1_q <= tag_arch('0);
			rs2_q <= tag_arch('0);
		end else if (!rename_stall) begin
			rs1_q <= src1_tag;
			rs2_q <= src2_tag;
		end else begin
			// producer finished while we wait, read the register file instead
			if (rs1_q.station.flag && commit_done[rs1_q.station.idx]) begin
				rs1_q <= tag_arch(real_rs1_q);
			end
			if (rs2_q.station.flag && commit_done[rs2_q.station.idx]) begin
				rs2_q <= tag_arch(real_rs2_q);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rename_stall) begin
			real_rs1_q <= rs1;
			real_rs2_q <= rs2;
			rd_q <= dest_idx;
			rd_real_q <= rd;
			makes_rd_q <= makes_rd;
			needs_rs2_q <= needs_rs2;
			control_q <= control;
			pc_q <= pc;
		end
	end

	assign valid_out = valid_q;
	assign rs1_out = rs1_q;
	assign rs2_out = rs2_q;
	assign rd_out = rd_q;
	assign rd_real_out = rd_real_q;
	assign makes_rd_out = makes_rd_q;
	assign needs_rs2_out = needs_rs2_q;
	assign control_out = control_q;
	assign pc_out = pc_q;

endmodule

`default_nettype wire

// File: hdl/rename_stage.sv
// ==========================================================
// register rename stage
// renames up to two of four decode entries per cycle onto
// a 16 entry commit window, one cycle of latency
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module rename_stage
	import rename_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic [`RN_NENTRY-1:0] entry_valid,
	input  wire arch_reg_t rs1 [`RN_NENTRY],
	input  wire arch_reg_t rs2 [`RN_NENTRY],
	input  wire arch_reg_t rd [`RN_NENTRY],
	input  wire logic [`RN_NENTRY-1:0] needs_rs2,
	input  wire logic [`RN_NENTRY-1:0] makes_rd,
	input  wire logic [`RN_CNTRL_SIZE-1:0] control [`RN_NENTRY],
	input  wire logic [`RN_VA_SZ-1:0] pc [`RN_NENTRY],
	input  wire commit_idx_t next_start,
	input  wire logic [`RN_LNCOMMIT:0] current_available,
	input  wire logic [`RN_NCOMMIT-1:0] commit_done,
	input  wire logic [`RN_NCOMMIT-1:0] commit_retire,
	input  wire logic commit_br_enable,
	output logic [`RN_NSLOT-1:0] valid_out,
	output reg_tag_t rs1_out [`RN_NSLOT],
	output reg_tag_t rs2_out [`RN_NSLOT],
	output commit_idx_t rd_out [`RN_NSLOT],
	output arch_reg_t rd_real_out [`RN_NSLOT],
	output logic [`RN_NSLOT-1:0] makes_rd_out,
	output logic [`RN_NSLOT-1:0] needs_rs2_out,
	output logic [`RN_CNTRL_SIZE-1:0] control_out [`RN_NSLOT],
	output logic [`RN_VA_SZ-1:0] pc_out [`RN_NSLOT],
	output logic [$clog2(`RN_NSLOT+1)-1:0] count_out,
	output logic rename_stall,
	output logic rename_reloading
);

	logic [`RN_NSLOT-1:0] slot_valid;
	entry_idx_t slot_entry [`RN_NSLOT];
	logic accept;
	reg_tag_t reg_tag [`RN_NARCH];
	reg_tag_t src1_tag [`RN_NSLOT];
	reg_tag_t src2_tag [`RN_NSLOT];
	commit_idx_t dest_idx [`RN_NSLOT];
	logic [`RN_NSLOT-1:0] upd_valid;
	arch_reg_t sel_rd [`RN_NSLOT];

	entry_select u_entry_select (
		.entry_valid(entry_valid),
		.slot_valid(slot_valid),
		.slot_entry(slot_entry)
	);

	rename_ctrl u_rename_ctrl (
		.clk(clk),
		.reset(reset),
		.slot_valid(slot_valid),
		.current_available(current_available),
		.commit_br_enable(commit_br_enable),
		.accept(accept),
		.count_out(count_out),
		.rename_stall(rename_stall),
		.rename_reloading(rename_reloading)
	);

	reg_scoreboard u_reg_scoreboard (
		.clk(clk),
		.reset(reset),
		.accept(accept),
		.upd_valid(upd_valid),
		.upd_reg(sel_rd),
		.upd_idx(dest_idx),
		.commit_retire(commit_retire),
		.commit_br_enable(commit_br_enable),
		.reg_tag(reg_tag)
	);

	operand_map u_operand_map (
		.slot_valid(slot_valid),
		.slot_entry(slot_entry),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.makes_rd(makes_rd),
		.next_start(next_start),
		.reg_tag(reg_tag),
		.commit_done(commit_done),
		.src1_tag(src1_tag),
		.src2_tag(src2_tag),
		.dest_idx(dest_idx),
		.upd_valid(upd_valid)
	);

	for (genvar k = 0; k < `RN_NSLOT; k++) begin : g_slot
		assign sel_rd[k] = rd[slot_entry[k]];

		rename_slot u_rename_slot (
			.clk(clk),
			.reset(reset),
			.accept(accept),
			.rename_stall(rename_stall),
			.slot_valid_in(slot_valid[k]),
			.src1_tag(src1_tag[k]),
			.src2_tag(src2_tag[k]),
			.dest_idx(dest_idx[k]),
			.rs1(rs1[slot_entry[k]]),
			.rs2(rs2[slot_entry[k]]),
			.rd(sel_rd[k]),
			.needs_rs2(needs_rs2[slot_entry[k]]),
			.makes_rd(makes_rd[slot_entry[k]]),
			.control(control[slot_entry[k]]),
			.pc(pc[slot_entry[k]]),
			.commit_done(commit_done),
			.valid_out(valid_out[k]),
			.rs1_out(rs1_out[k]),
			.rs2_out(rs2_out[k]),
			.rd_out(rd_out[k]),
			.rd_real_out(rd_real_out[k]),
			.makes_rd_out(makes_rd_out[k]),
			.needs_rs2_out(needs_rs2_out[k]),
			.control_out(control_out[k]),
			.pc_out(pc_out[k])
		);
	end

endmodule

`default_nettype wire

// File: sim/rename_assert.sv
// ==========================================================
// rename stage assertions
// stall and valid, reload window length after a flush,
// and count against the free stations
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module rename_assert (
	input wire logic clk,
	input wire logic reset,
	input wire logic [`RN_NSLOT-1:0] valid_out,
	input wire logic rename_stall,
	input wire logic rename_reloading,
	input wire logic commit_br_enable,
	input wire logic [1:0] count_out,
	input wire logic [`RN_LNCOMMIT:0] current_available
);

	// a stalled group is never presented
	a_no_valid_after_stall: assert property (@(posedge clk) disable iff (reset)
		rename_stall |=> valid_out == '0)
		else $error("valid_out high in the cycle after a stall");

	// reload window covers exactly the two cycles after a flush
	a_reload_window: assert property (@(posedge clk) disable iff (reset)
		rename_reloading == ($past(commit_br_enable) || $past(commit_br_enable, 2)))
		else $error("rename_reloading does not match the two cycles after a flush");

	a_count_fits: assert property (@(posedge clk) disable iff (reset)
		count_out <= current_available)
		else $error("count_out exceeds current_available");

endmodule

bind rename_stage rename_assert u_rename_assert (
	.clk(clk),
	.reset(reset),
	.valid_out(valid_out),
	.rename_stall(rename_stall),
	.rename_reloading(rename_reloading),
	.commit_br_enable(commit_br_enable),
	.count_out(count_out),
	.current_available(current_available)
);

`default_nettype wire

// File: sim/rename_tb.sv
// ==========================================================
// rename stage testbench
// random decode groups against a behavioral commit unit,
// a reference model of the scoreboard and slot registers,
// and directed stall and flush sequences
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "rename_config.svh"

module rename_tb
	import rename_pkg::*;
();

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 200;
	localparam int STALL_CYCLES = 40;
	localparam int FLUSH_CYCLES = 30;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 3 * RANDOM_CYCLES + STALL_CYCLES +
		FLUSH_CYCLES + 20;

	logic clk = 1'b0;
	logic reset;
	logic [`RN_NENTRY-1:0] entry_valid;
	arch_reg_t rs1 [`RN_NENTRY];
	arch_reg_t rs2 [`RN_NENTRY];
	arch_reg_t rd [`RN_NENTRY];
	logic [`RN_NENTRY-1:0] needs_rs2;
	logic [`RN_NENTRY-1:0] makes_rd;
	logic [`RN_CNTRL_SIZE-1:0] control [`RN_NENTRY];
	logic [`RN_VA_SZ-1:0] pc [`RN_NENTRY];
	commit_idx_t next_start;
	logic [`RN_LNCOMMIT:0] current_available;
	logic [`RN_NCOMMIT-1:0] commit_done;
	logic [`RN_NCOMMIT-1:0] commit_retire;
	logic commit_br_enable;
	logic [`RN_NSLOT-1:0] valid_out;
	reg_tag_t rs1_out [`RN_NSLOT];
	reg_tag_t rs2_out [`RN_NSLOT];
	commit_idx_t rd_out [`RN_NSLOT];
	arch_reg_t rd_real_out [`RN_NSLOT];
	logic [`RN_NSLOT-1:0] makes_rd_out;
	logic [`RN_NSLOT-1:0] needs_rs2_out;
	logic [`RN_CNTRL_SIZE-1:0] control_out [`RN_NSLOT];
	logic [`RN_VA_SZ-1:0] pc_out [`RN_NSLOT];
	logic [1:0] count_out;
	logic rename_stall;
	logic rename_reloading;

	// model state, scoreboard plus commit unit
	logic [5:0] sb_tag [`RN_NARCH];
	logic [1:0] flush_sr_m;
	commit_idx_t inflight [$];
	logic [`RN_NCOMMIT-1:0] done_state;
	commit_idx_t alloc_ptr;
	logic hold_entries;

	// expected outputs
	logic [1:0] exp_count;
	logic exp_stall;
	logic exp_reload;
	logic [1:0] exp_valid;
	logic [1:0] known;
	logic [5:0] exp_rs1 [2];
	logic [5:0] exp_rs2 [2];
	arch_reg_t exp_real1 [2];
	arch_reg_t exp_real2 [2];
	commit_idx_t exp_rd [2];
	arch_reg_t exp_rd_real [2];
	logic [1:0] exp_mk;
	logic [1:0] exp_nd;
	logic [`RN_CNTRL_SIZE-1:0] exp_ctl [2];
	logic [`RN_VA_SZ-1:0] exp_pc [2];

	logic [31:0] lfsr_state = 32'h6089_54a5;
	logic checking = 1'b0;
	int check_count = 0;
	int err_count = 0;
	int cycle_count = 0;

	rename_stage u_rename_stage (.*);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [5:0] arch_tag(arch_reg_t r);
		return {1'b0, r};
	endfunction

	function automatic logic [5:0] station_tag(commit_idx_t idx);
		return {2'b10, idx};
	endfunction

	function automatic logic [5:0] map_source(arch_reg_t src, logic byp, arch_reg_t byp_reg,
		commit_idx_t byp_idx);
		logic [5:0] t;
		t = sb_tag[src];
		if (byp && byp_reg == src) begin
			t = station_tag(byp_idx);
		end
		if (t[5] && commit_done[t[3:0]]) begin
			t = arch_tag(src);
		end
		if (src == '0) begin
			t = arch_tag('0);
		end
		return t;
	endfunction

	// reference model for one cycle, from the inputs now driven
	function automatic void predict_cycle();
		int sel [2];
		int n;
		int needed;
		logic [1:0] sv;
		logic [1:0] upd;
		logic acc;
		n = 0;
		sv = '0;
		sel[0] = 0;
		sel[1] = 0;
		for (int i = 0; i < `RN_NENTRY; i++) begin
			if (entry_valid[i]) begin
				if (n < 2) begin
					sv[n] = 1'b1;
					sel[n] = i;
				end
				n++;
			end
		end
		needed = sv[0] + sv[1];
		exp_stall = needed > current_available;
		exp_reload = |flush_sr_m;
		acc = sv != '0 && !exp_stall && !exp_reload;
		exp_count = acc ? 2'(needed) : 2'd0;
		for (int k = 0; k < 2; k++) begin
			upd[k] = sv[k] && makes_rd[sel[k]] && rd[sel[k]] != '0;
		end
		for (int k = 0; k < 2; k++) begin
			exp_valid[k] = sv[k] && acc;
			if (!exp_stall) begin
				exp_rs1[k] = map_source(rs1[sel[k]], k == 1 && upd[0], rd[sel[0]], next_start);
				exp_rs2[k] = map_source(rs2[sel[k]], k == 1 && upd[0], rd[sel[0]], next_start);
				exp_real1[k] = rs1[sel[k]];
				exp_real2[k] = rs2[sel[k]];
				exp_rd[k] = next_start + commit_idx_t'(k);
				exp_rd_real[k] = rd[sel[k]];
				exp_mk[k] = makes_rd[sel[k]];
				exp_nd[k] = needs_rs2[sel[k]];
				exp_ctl[k] = control[sel[k]];
				exp_pc[k] = pc[sel[k]];
				known[k] = sv[k];
			end else begin
				if (exp_rs1[k][5] && commit_done[exp_rs1[k][3:0]]) begin
					exp_rs1[k] = arch_tag(exp_real1[k]);
				end
				if (exp_rs2[k][5] && commit_done[exp_rs2[k][3:0]]) begin
					exp_rs2[k] = arch_tag(exp_real2[k]);
				end
			end
		end
		for (int r = 1; r < `RN_NARCH; r++) begin
			if (commit_br_enable) begin
				sb_tag[r] = arch_tag(arch_reg_t'(r));
			end else if (sb_tag[r][5] && commit_retire[sb_tag[r][3:0]]) begin
				sb_tag[r] = arch_tag(arch_reg_t'(r));
			end
		end
		if (acc && !commit_br_enable) begin
			for (int k = 0; k < 2; k++) begin
				if (upd[k]) begin
					sb_tag[rd[sel[k]]] = station_tag(next_start + commit_idx_t'(k));
				end
			end
		end
		flush_sr_m = {flush_sr_m[0], commit_br_enable};
	endfunction

	task automatic check_field(string what, logic [31:0] got, logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("** Error @ %0t: %s got %h expected %h", $time, what, got, exp);
			err_count++;
		end
	endtask

	// comparing process, combinational outputs mid cycle and slot registers after the edge
	always begin
		@(negedge clk);
		#10;
		if (checking) begin
			check_field("count_out", count_out, exp_count);
			check_field("rename_stall", rename_stall, exp_stall);
			check_field("rename_reloading", rename_reloading, exp_reload);
		end
		@(posedge clk);
		#10;
		for (int k = 0; k < 2 && checking; k++) begin
			check_field($sformatf("slot%0d valid_out", k), valid_out[k], exp_valid[k]);
			if (known[k]) begin
				check_field($sformatf("slot%0d rs1_out", k), rs1_out[k], exp_rs1[k]);
				check_field($sformatf("slot%0d rs2_out", k), rs2_out[k], exp_rs2[k]);
				check_field($sformatf("slot%0d rd_out", k), rd_out[k], exp_rd[k]);
				check_field($sformatf("slot%0d rd_real_out", k), rd_real_out[k], exp_rd_real[k]);
				check_field($sformatf("slot%0d makes_rd_out", k), makes_rd_out[k], exp_mk[k]);
				check_field($sformatf("slot%0d needs_rs2_out", k), needs_rs2_out[k], exp_nd[k]);
				check_field($sformatf("slot%0d control_out", k), control_out[k], exp_ctl[k]);
				check_field($sformatf("slot%0d pc_out", k), pc_out[k], exp_pc[k]);
			end
		end
	end

	// one cycle of decode and commit unit activity, driven on the falling edge
	task automatic run_cycle(logic [4:0] mask, int done_bits, bit done_en, bit retire_en,
		bit full, bit flush);
		int n_ret;
		@(negedge clk);
		n_ret = 0;
		next_start = alloc_ptr;
		current_available = 5'(`RN_NCOMMIT - inflight.size());
		commit_retire = '0;
		for (int j = 0; j < 2 && retire_en; j++) begin
			if (inflight.size() > j && n_ret == j && done_state[inflight[j]] && take_bits(1)) begin
				commit_retire[inflight[j]] = 1'b1;
				n_ret++;
			end
		end
		commit_done = done_state;
		commit_br_enable = flush;
		// decode keeps an unaccepted group in place
		if (!hold_entries) begin
			entry_valid = full ? 4'hf : 4'(take_bits(4));
			for (int i = 0; i < `RN_NENTRY; i++) begin
				rs1[i] = arch_reg_t'(take_bits(5)) & mask;
				rs2[i] = arch_reg_t'(take_bits(5)) & mask;
				rd[i] = arch_reg_t'(take_bits(5)) & mask;
				needs_rs2[i] = take_bits(1);
				makes_rd[i] = take_bits(1);
				control[i] = take_bits(7);
				pc[i] = take_bits(32);
			end
		end
		if (flush) begin
			entry_valid = '0;
		end
		predict_cycle();
		if (flush) begin
			inflight.delete();
			done_state = '0;
		end else begin
			repeat (n_ret) begin
				done_state[inflight[0]] = 1'b0;
				void'(inflight.pop_front());
			end
			for (int i = 0; i < exp_count; i++) begin
				inflight.push_back(alloc_ptr);
				alloc_ptr++;
			end
		end
		for (int j = 0; j < inflight.size() && done_en; j++) begin
			if (take_bits(done_bits) == 0) begin
				done_state[inflight[j]] = 1'b1;
			end
		end
		hold_entries = entry_valid != '0 && exp_count == '0;
	endtask

	task automatic report_test(string name, int c0, int e0);
		@(posedge clk);
		#15;
		$display("test %s: %0d checks, %0d errors", name, check_count - c0, err_count - e0);
	endtask

	task automatic run_random(string name, logic [4:0] mask, int done_bits);
		int c0;
		int e0;
		c0 = check_count;
		e0 = err_count;
		repeat (RANDOM_CYCLES) run_cycle(mask, done_bits, 1, 1, 0, 0);
		report_test(name, c0, e0);
	endtask

	task automatic run_stall_test();
		int c0;
		int e0;
		bit saw;
		c0 = check_count;
		e0 = err_count;
		saw = 0;
		// fill the window with nothing finishing
		for (int i = 0; i < 12 && !saw; i++) begin
			run_cycle(5'h1f, 1, 0, 0, 1, 0);
			saw = exp_stall;
		end
		assert (saw) else begin
			$display("stall test: the commit window never filled, so no stall was seen");
			err_count++;
		end
		repeat (3) run_cycle(5'h1f, 1, 0, 0, 1, 0);
		// producers finish while the group is held
		repeat (6) run_cycle(5'h1f, 1, 1, 0, 1, 0);
		repeat (12) run_cycle(5'h1f, 1, 1, 1, 1, 0);
		report_test("stall", c0, e0);
	endtask

	task automatic run_flush_test();
		int c0;
		int e0;
		c0 = check_count;
		e0 = err_count;
		repeat (10) run_cycle(5'h0f, 3, 1, 1, 0, 0);
		run_cycle(5'h0f, 3, 1, 1, 0, 1);
		repeat (4) run_cycle(5'h0f, 3, 1, 1, 1, 0);
		repeat (10) run_cycle(5'h0f, 3, 1, 1, 0, 0);
		report_test("flush", c0, e0);
	endtask

	initial begin
		reset = 1'b1;
		entry_valid = '0;
		for (int i = 0; i < `RN_NENTRY; i++) begin
			rs1[i] = '0;
			rs2[i] = '0;
			rd[i] = '0;
			control[i] = '0;
			pc[i] = '0;
		end
		needs_rs2 = '0;
		makes_rd = '0;
		next_start = '0;
		current_available = 5'(`RN_NCOMMIT);
		commit_done = '0;
		commit_retire = '0;
		commit_br_enable = 1'b0;
		for (int r = 0; r < `RN_NARCH; r++) begin
			sb_tag[r] = arch_tag(arch_reg_t'(r));
		end
		flush_sr_m = '0;
		done_state = '0;
		alloc_ptr = '0;
		hold_entries = 1'b0;
		exp_count = '0;
		exp_stall = 1'b0;
		exp_reload = 1'b0;
		exp_valid = '0;
		known = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		check_field("reset rename_stall", rename_stall, 0);
		check_field("reset rename_reloading", rename_reloading, 0);
		for (int k = 0; k < 2; k++) begin
			check_field($sformatf("reset slot%0d valid_out", k), valid_out[k], 0);
			check_field($sformatf("reset slot%0d rs1_out", k), rs1_out[k], arch_tag('0));
			check_field($sformatf("reset slot%0d rs2_out", k), rs2_out[k], arch_tag('0));
		end
		$display("test reset: %0d checks, %0d errors", check_count, err_count);
		@(negedge clk);
		reset = 1'b0;
		checking = 1'b1;
		run_random("select", 5'h1f, 2);
		run_random("chain", 5'h07, 3);
		run_random("retire", 5'h0f, 1);
		run_stall_test();
		run_flush_test();
		$display("summary: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/entry_select.sv
hdl/rename_ctrl.sv
hdl/reg_scoreboard.sv
hdl/operand_map.sv
hdl/rename_slot.sv
hdl/rename_stage.sv
sim/rename_assert.sv
sim/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rename_pkg.sv
      - hdl/entry_select.sv
      - hdl/rename_ctrl.sv
      - hdl/reg_scoreboard.sv
      - hdl/operand_map.sv
      - hdl/rename_slot.sv
      - hdl/rename_stage.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/rename_assert.sv
      - sim/rename_tb.sv
